// File: include/rpDrive_macros.svh
////////////////////
// RP06 drive register subsystem constants
// Geometry, register selects, function codes, status bits, timing
////////////////////
`ifndef RPDRIVE_MACROS_SVH
`define RPDRIVE_MACROS_SVH

// Geometry, last valid value of each address field
`define RP_LAST_SECTOR   6'd21
`define RP_LAST_TRACK    6'd18
`define RP_LAST_CYL      10'd814

// Register selects
`define RP_SEL_CS1       3'd0
`define RP_SEL_DA        3'd1
`define RP_SEL_DC        3'd2
`define RP_SEL_DS        3'd3
`define RP_SEL_ER1       3'd4
`define RP_SEL_AS        3'd5

// Function codes, command bits 5:1
`define RP_FN_SEEK       5'd2
`define RP_FN_DRVCLR     5'd4
`define RP_FN_OFFSET     5'd6
`define RP_FN_CENTER     5'd7
`define RP_FN_PRESET     5'd8
`define RP_FN_PAKACK     5'd9

// Status bit positions
`define RP_DS_ATA        15
`define RP_DS_ERR        14
`define RP_DS_PIP        13
`define RP_DS_MOL        12
`define RP_DS_WRL        11
`define RP_DS_LST        10
`define RP_DS_DPR        8
`define RP_DS_DRY        7
`define RP_DS_VV         6
`define RP_DS_OM         0

// Error register 1, invalid address
`define RP_ER1_IAE       10

// Command timing in clock cycles
`define RP_SEEK_CYCLES   20
`define RP_OFFSET_CYCLES 6

`endif

// File: hw/rpPkg.sv
////////////////////
// RP06 drive types
// Register field vectors and the drive command state encoding
////////////////////
package rpPkg;

   ////////////////////
   // Register fields
   ////////////////////

   // Full register word as seen by the host
   typedef logic [15:0] rpWord_t;

   // Disk address fields
   typedef logic [5:0]  rpSector_t;
   typedef logic [5:0]  rpTrack_t;

   // Desired cylinder field
   typedef logic [9:0]  rpCyl_t;

   // Host register select
   typedef logic [2:0]  rpRegSel_t;

   // Command function code, CS1 bits 5:1
   typedef logic [4:0]  rpFunc_t;

   ////////////////////
   // Drive FSM
   ////////////////////

   // SEEKREQ waits for the positioner, SEEKDLY runs the seek delay
   typedef enum logic [3:0]
   {
      IDLE,
      CLEAR,
      PRESET,
      PAKACK,
      SEEKREQ,
      SEEKDLY,
      OFFSET,
      CENTER,
      ATA
   } rpState_t;

endpackage

// File: hw/rpRegIf.sv
////////////////////
// Register access path between the bus decoder and one drive
////////////////////
`timescale 1ns/1ps

interface rpRegIf;
   import rpPkg::*;

   // Write strobe, one cycle
   logic      wr;
   // Register select, shared by reads and writes
   rpRegSel_t sel;
   rpWord_t   wrData;
   // Attention clear pulse from an AS write
   logic      ataClr;
   // Read data for the current select
   rpWord_t   rdData;
   // Attention level of the drive
   logic      ata;

   // Bus decoder side
   modport bus
   (
      output wr, sel, wrData, ataClr,
      input  rdData, ata
   );

   // Drive side
   modport drive
   (
      input  wr, sel, wrData, ataClr,
      output rdData, ata
   );

endinterface

// File: hw/rpMediaIf.sv
////////////////////
// Positioner request and grant between one drive and the arbiter
////////////////////
`timescale 1ns/1ps

interface rpMediaIf;
   import rpPkg::*;

   // Held high from request until done
   logic   req;
   // Target cylinder of the seek
   rpCyl_t cyl;
   // Positioner owned by this drive
   logic   gnt;
   // End of seek delay, one cycle
   logic   done;

   // Drive side
   modport drive
   (
      output req, cyl,
      input  gnt, done
   );

   // Arbiter side
   modport arb
   (
      input  req, cyl,
      output gnt, done
   );

endinterface

// File: hw/rpStatus.sv
////////////////////
// RP06 drive status word
// Holds ATA, VV and OM and builds the 16-bit DS register
////////////////////
`timescale 1ns/1ps
`include "rpDrive_macros.svh"

module rpStatus
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            ataClr,
   input  rpPkg::rpState_t state,
   input  logic            cd,
   input  logic            wp,
   input  rpPkg::rpWord_t  da,
   input  rpPkg::rpWord_t  dc,
   input  rpPkg::rpWord_t  er1,
   output rpPkg::rpWord_t  ds
);
   import rpPkg::*;

   logic      ata;
   logic      vv;
   logic      om;
   logic      lst;
   rpSector_t sector;
   rpTrack_t  track;
   rpCyl_t    cyl;

   ////////////////////
   // Status flip-flops
   ////////////////////

   // Attention, set when a command reports completion
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (clr || ataClr || state == CLEAR)
         ata <= 1'b0;
      else if (state == ATA)
         ata <= 1'b1;
   end

   // Volume valid, lost as soon as the media goes away
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         vv <= 1'b0;
      else if (clr)
         vv <= 1'b0;
      else
      begin
         case (state)
            IDLE:    vv <= vv & cd;
            PRESET:  vv <= cd;
            PAKACK:  vv <= cd;
            default: vv <= vv;
         endcase
      end
   end

   // Offset mode
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         om <= 1'b0;
      else if (clr)
         om <= 1'b0;
      else if (state == OFFSET)
         om <= 1'b1;
      else if (state == CENTER)
         om <= 1'b0;
   end

   ////////////////////
   // Status word
   ////////////////////

   // Address fields, track sits in DA bits 13:8
   assign sector = da[5:0];
   assign track  = da[13:8];
   assign cyl    = dc[9:0];
   assign lst    = sector == `RP_LAST_SECTOR && track == `RP_LAST_TRACK &&
                   cyl == `RP_LAST_CYL;

   always_comb
   begin
      // PGM and bits 5:1 stay zero
      ds = '0;
      ds[`RP_DS_ATA] = ata;
      ds[`RP_DS_ERR] = er1 != '0;
      ds[`RP_DS_PIP] = state == SEEKREQ || state == SEEKDLY;
      ds[`RP_DS_MOL] = cd;
      ds[`RP_DS_WRL] = wp;
      ds[`RP_DS_LST] = lst;
      ds[`RP_DS_DPR] = 1'b1;
      ds[`RP_DS_DRY] = state == IDLE;
      ds[`RP_DS_VV]  = vv;
      ds[`RP_DS_OM]  = om;
   end

   // Ready and positioning are exclusive phases of the drive
   dryPipExcl: assert property (@(posedge clk) disable iff (rst)
      !(ds[`RP_DS_DRY] && ds[`RP_DS_PIP]));

endmodule

// File: hw/rpDrive.sv
////////////////////
// One RP06 drive
// DA, DC and ER1 registers, command FSM and status word
////////////////////
`timescale 1ns/1ps
`include "rpDrive_macros.svh"

module rpDrive
(
   input  logic    clk,
   input  logic    rst,
   input  logic    cd,
   input  logic    wp,
   rpRegIf.drive   regs,
   rpMediaIf.drive media
);
   import rpPkg::*;

   localparam int DlyW = $clog2(`RP_OFFSET_CYCLES);

   rpState_t        state;
   rpWord_t         da;
   rpWord_t         dc;
   rpWord_t         er1;
   rpWord_t         ds;
   rpFunc_t         func;
   rpFunc_t         wrFunc;
   rpCyl_t          cyl;
   logic [DlyW-1:0] dlyCnt;
   logic            goWr;
   logic            clr;
   logic            badCyl;

   ////////////////////
   // Command decode
   ////////////////////

   // GO accepted only while idle
   assign wrFunc = regs.wrData[5:1];
   assign goWr   = regs.wr && regs.sel == `RP_SEL_CS1 && regs.wrData[0] && state == IDLE;
   // Drive clear pulse at command accept
   assign clr    = goWr && wrFunc == `RP_FN_DRVCLR;
   assign cyl    = dc[9:0];
   assign badCyl = cyl > `RP_LAST_CYL;

   ////////////////////
   // Drive FSM
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= IDLE;
         dlyCnt <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               dlyCnt <= '0;
               if (goWr)
               begin
                  case (wrFunc)
                     `RP_FN_DRVCLR: state <= CLEAR;
                     `RP_FN_SEEK:   state <= badCyl ? ATA : SEEKREQ;
                     `RP_FN_OFFSET: state <= OFFSET;
                     `RP_FN_CENTER: state <= CENTER;
                     `RP_FN_PRESET: state <= PRESET;
                     `RP_FN_PAKACK: state <= PAKACK;
                     // Unsupported functions are dropped
                     default:       state <= IDLE;
                  endcase
               end
            end
            // Wait for the shared positioner
            SEEKREQ:
               if (media.gnt)
                  state <= SEEKDLY;
            SEEKDLY:
               if (media.done)
                  state <= ATA;
            // Head offset and return to center
            OFFSET, CENTER:
            begin
               if (dlyCnt == DlyW'(`RP_OFFSET_CYCLES - 1))
                  state <= ATA;
               else
                  dlyCnt <= dlyCnt + 1'b1;
            end
            // CLEAR, PRESET, PAKACK and ATA are single cycle
            default:
               state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Drive registers
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         da   <= '0;
         dc   <= '0;
         er1  <= '0;
         func <= '0;
      end
      else
      begin
         // Preset zeroes the address registers
         if (state == PRESET)
         begin
            da <= '0;
            dc <= '0;
         end
         else if (regs.wr && regs.sel == `RP_SEL_DA)
            da <= regs.wrData;
         else if (regs.wr && regs.sel == `RP_SEL_DC)
            dc <= regs.wrData;
         // Error register 1
         if (state == CLEAR || state == PRESET)
            er1 <= '0;
         else if (goWr && wrFunc == `RP_FN_SEEK && badCyl)
            er1[`RP_ER1_IAE] <= 1'b1;
         // Last accepted function, read back in CS1
         if (goWr)
            func <= wrFunc;
      end
   end

   // Read mux, GO reads back while busy
   always_comb
   begin
      case (regs.sel)
         `RP_SEL_CS1: regs.rdData = {10'b0, func, state != IDLE};
         `RP_SEL_DA:  regs.rdData = da;
         `RP_SEL_DC:  regs.rdData = dc;
         `RP_SEL_DS:  regs.rdData = ds;
         `RP_SEL_ER1: regs.rdData = er1;
         default:     regs.rdData = '0;
      endcase
   end

   assign regs.ata  = ds[`RP_DS_ATA];
   assign media.req = state == SEEKREQ || state == SEEKDLY;
   assign media.cyl = cyl;

   // Status word
   rpStatus u_rpStatus
   (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .ataClr (regs.ataClr),
      .state  (state),
      .cd     (cd),
      .wp     (wp),
      .da     (da),
      .dc     (dc),
      .er1    (er1),
      .ds     (ds)
   );

   // Request is held until the positioner reports done
   reqHeld: assert property (@(posedge clk) disable iff (rst)
      $fell(media.req) |-> $past(media.done));

endmodule

// File: hw/rpMassbus.sv
////////////////////
// Register bus decoder
// Routes host writes, muxes read data, owns attention summary
////////////////////
`timescale 1ns/1ps
`include "rpDrive_macros.svh"

module rpMassbus
(
   input  logic              regWr,
   input  logic              regDrive,
   input  rpPkg::rpRegSel_t  regSel,
   input  rpPkg::rpWord_t    regWrData,
   output rpPkg::rpWord_t    regRdData,
   rpRegIf.bus               drv0,
   rpRegIf.bus               drv1
);

   logic selAs;

   // AS is shared by both drives
   assign selAs = regSel == `RP_SEL_AS;

   ////////////////////
   // Write routing
   ////////////////////

   // Per drive register writes
   assign drv0.wr     = regWr && !selAs && !regDrive;
   assign drv1.wr     = regWr && !selAs && regDrive;
   assign drv0.sel    = regSel;
   assign drv1.sel    = regSel;
   assign drv0.wrData = regWrData;
   assign drv1.wrData = regWrData;

   // AS write clears attention, one bit per drive
   assign drv0.ataClr = regWr && selAs && regWrData[0];
   assign drv1.ataClr = regWr && selAs && regWrData[1];

   ////////////////////
   // Read mux
   ////////////////////

   always_comb
   begin
      if (selAs)
         regRdData = {14'b0, drv1.ata, drv0.ata};
      else if (regDrive)
         regRdData = drv1.rdData;
      else
         regRdData = drv0.rdData;
   end

endmodule

// File: hw/rpPositioner.sv
////////////////////
// Shared head positioner
// Round-robin grant between two drives and the seek delay
////////////////////
`timescale 1ns/1ps
`include "rpDrive_macros.svh"

module rpPositioner
(
   input  logic  clk,
   input  logic  rst,
   rpMediaIf.arb m0,
   rpMediaIf.arb m1
);

   localparam int CntW = $clog2(`RP_SEEK_CYCLES);

   logic [1:0]      req;
   logic [1:0]      gnt;
   logic [1:0]      done;
   // Low favors drive 0
   logic            ptr;
   logic [CntW-1:0] cnt;

   assign req = {m1.req, m0.req};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         gnt  <= '0;
         done <= '0;
         ptr  <= 1'b0;
         cnt  <= '0;
      end
      else
      begin
         done <= '0;
         if (gnt != 2'b00)
         begin
            // End of seek, release and move past the served drive
            if (cnt == CntW'(`RP_SEEK_CYCLES - 1))
            begin
               done <= gnt;
               gnt  <= '0;
               ptr  <= gnt[0];
               cnt  <= '0;
            end
            else
               cnt <= cnt + 1'b1;
         end
         // No new grant while the served drive still holds req
         else if (done == 2'b00)
         begin
            if (req[0] && (!ptr || !req[1]))
               gnt <= 2'b01;
            else if (req[1])
               gnt <= 2'b10;
         end
      end
   end

   assign m0.gnt  = gnt[0];
   assign m1.gnt  = gnt[1];
   assign m0.done = done[0];
   assign m1.done = done[1];

   // One owner at a time
   gntExcl: assert property (@(posedge clk) disable iff (rst)
      !(gnt[0] && gnt[1]));

   // Drives only ever send a valid cylinder to the heads
   cylValid: assert property (@(posedge clk) disable iff (rst)
      (!gnt[0] || m0.cyl <= `RP_LAST_CYL) && (!gnt[1] || m1.cyl <= `RP_LAST_CYL));

endmodule

// File: hw/rpDriveTop.sv
////////////////////
// Two-drive RP06 register subsystem top level
////////////////////
`timescale 1ns/1ps

module rpDriveTop
(
   input  logic              clk,
   input  logic              rst,
   input  logic              regWr,
   input  logic              regDrive,
   input  rpPkg::rpRegSel_t  regSel,
   input  rpPkg::rpWord_t    regWrData,
   output rpPkg::rpWord_t    regRdData,
   input  logic [1:0]        cd,
   input  logic [1:0]        wp
);

   // Register paths, one per drive
   rpRegIf   regIf0 ();
   rpRegIf   regIf1 ();
   // Positioner paths, one per drive
   rpMediaIf mediaIf0 ();
   rpMediaIf mediaIf1 ();

   rpMassbus u_rpMassbus
   (
      .regWr     (regWr),
      .regDrive  (regDrive),
      .regSel    (regSel),
      .regWrData (regWrData),
      .regRdData (regRdData),
      .drv0      (regIf0.bus),
      .drv1      (regIf1.bus)
   );

   rpDrive u_rpDrive0
   (
      .clk   (clk),
      .rst   (rst),
      .cd    (cd[0]),
      .wp    (wp[0]),
      .regs  (regIf0.drive),
      .media (mediaIf0.drive)
   );

   rpDrive u_rpDrive1
   (
      .clk   (clk),
      .rst   (rst),
      .cd    (cd[1]),
      .wp    (wp[1]),
      .regs  (regIf1.drive),
      .media (mediaIf1.drive)
   );

   // Shared head positioner
   rpPositioner u_rpPositioner
   (
      .clk (clk),
      .rst (rst),
      .m0  (mediaIf0.arb),
      .m1  (mediaIf1.arb)
   );

endmodule

// File: verification/rpDriveTb.sv
////////////////////
// RP06 two-drive register subsystem testbench
// Directed tests over status, addressing, seeks and positioner sharing
////////////////////
`timescale 1ns/1ps
`include "rpDrive_macros.svh"

module rpDriveTb;
   import rpPkg::*;

   logic      clk;
   logic      rst;
   logic      regWr;
   logic      regDrive;
   rpRegSel_t regSel;
   rpWord_t   regWrData;
   rpWord_t   regRdData;
   logic [1:0] cd;
   logic [1:0] wp;
   integer    seed;

   rpDriveTop u_rpDriveTop
   (
      .clk       (clk),
      .rst       (rst),
      .regWr     (regWr),
      .regDrive  (regDrive),
      .regSel    (regSel),
      .regWrData (regWrData),
      .regRdData (regRdData),
      .cd        (cd),
      .wp        (wp)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   // Stops the run on the first wrong value
   task automatic check(input string name, input logic [15:0] actual,
                        input logic [15:0] expected);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "value check failed");
      end
   endtask

   // CS1 word with GO set
   function automatic rpWord_t cmdWord(input rpFunc_t fn);
      return {10'b0, fn, 1'b1};
   endfunction

   // Expected DS, DPR always set
   function automatic rpWord_t dsWord(input logic ata, input logic err, input logic pip,
                                      input logic mol, input logic wrl, input logic lst,
                                      input logic dry, input logic vv, input logic om);
      rpWord_t w;
      w = '0;
      w[`RP_DS_ATA] = ata;
      w[`RP_DS_ERR] = err;
      w[`RP_DS_PIP] = pip;
      w[`RP_DS_MOL] = mol;
      w[`RP_DS_WRL] = wrl;
      w[`RP_DS_LST] = lst;
      w[`RP_DS_DPR] = 1'b1;
      w[`RP_DS_DRY] = dry;
      w[`RP_DS_VV]  = vv;
      w[`RP_DS_OM]  = om;
      return w;
   endfunction

   // Called 1 ns after an edge, returns 1 ns after the write edge
   task automatic regWrite(input logic drv, input rpRegSel_t sel, input rpWord_t data);
      regWr     = 1'b1;
      regDrive  = drv;
      regSel    = sel;
      regWrData = data;
      @(posedge clk);
      #1;
      regWr     = 1'b0;
   endtask

   // Read data is combinational, sampled mid cycle
   task automatic regRead(input logic drv, input rpRegSel_t sel, output rpWord_t data);
      regDrive = drv;
      regSel   = sel;
      #1;
      data = regRdData;
      @(posedge clk);
      #1;
   endtask

   task automatic checkReg(input logic drv, input rpRegSel_t sel, input rpWord_t expected,
                           input string name);
      rpWord_t data;
      regRead(drv, sel, data);
      check($sformatf("drive%0d %s", drv, name), data, expected);
   endtask

   // Single DS bit of one drive
   task automatic checkDsBit(input logic drv, input int bitPos, input logic expected,
                             input string name);
      rpWord_t data;
      regRead(drv, `RP_SEL_DS, data);
      check($sformatf("drive%0d DS.%s", drv, name), {15'b0, data[bitPos]}, {15'b0, expected});
   endtask

   // Poll a status bit, bounded at 200 reads
   task automatic waitStatus(input logic drv, input int bitPos, input logic val);
      rpWord_t data;
      int      cycles;
      cycles = 0;
      regRead(drv, `RP_SEL_DS, data);
      while (data[bitPos] !== val && cycles < 200)
      begin
         regRead(drv, `RP_SEL_DS, data);
         cycles++;
      end
      if (data[bitPos] !== val)
      begin
         $display("Timeout: drive %0d status bit %0d never reached %0b", drv, bitPos, val);
         $display("RESULT: FAIL");
         $fatal(1, "status wait timed out");
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic testResetStatus();
      checkReg(0, `RP_SEL_DS, dsWord(0, 0, 0, 1, 0, 0, 1, 0, 0), "DS");
      checkReg(1, `RP_SEL_DS, dsWord(0, 0, 0, 1, 0, 0, 1, 0, 0), "DS");
      checkReg(0, `RP_SEL_AS, 16'h0000, "AS");
   endtask

   task automatic testPresetPack();
      // Nonzero addresses so the preset clear is visible
      regWrite(0, `RP_SEL_DA, 16'h1234);
      regWrite(0, `RP_SEL_DC, 16'h0155);
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_PRESET));
      waitStatus(0, `RP_DS_DRY, 1'b1);
      checkReg(0, `RP_SEL_DA, 16'h0000, "DA");
      checkReg(0, `RP_SEL_DC, 16'h0000, "DC");
      checkReg(0, `RP_SEL_DS, dsWord(0, 0, 0, 1, 0, 0, 1, 1, 0), "DS after preset");
      // Write lock follows wp
      wp[0] = 1'b1;
      checkDsBit(0, `RP_DS_WRL, 1'b1, "WRL");
      wp[0] = 1'b0;
      // Media removed while idle drops VV
      cd[0] = 1'b0;
      @(posedge clk);
      #1;
      checkReg(0, `RP_SEL_DS, dsWord(0, 0, 0, 0, 0, 0, 1, 0, 0), "DS without media");
      cd[0] = 1'b1;
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_PAKACK));
      waitStatus(0, `RP_DS_DRY, 1'b1);
      checkReg(0, `RP_SEL_DS, dsWord(0, 0, 0, 1, 0, 0, 1, 1, 0), "DS after pack ack");
   endtask

   task automatic testLastSector();
      rpWord_t   da;
      rpWord_t   dc;
      rpSector_t sec;
      rpTrack_t  trk;
      rpCyl_t    cyl;
      logic      lst;
      for (int i = 0; i < 6; i++)
      begin
         da = rpWord_t'($random(seed));
         dc = rpWord_t'($random(seed));
         // Hit and near miss of the last block
         if (i == 4)
         begin
            da = {2'b10, `RP_LAST_TRACK, 2'b01, `RP_LAST_SECTOR};
            dc = {6'b0, `RP_LAST_CYL};
         end
         else if (i == 5)
         begin
            da = {2'b00, `RP_LAST_TRACK, 2'b00, 6'd20};
            dc = {6'b0, `RP_LAST_CYL};
         end
         sec = da[5:0];
         trk = da[13:8];
         cyl = dc[9:0];
         lst = sec == 6'd21 && trk == 6'd18 && cyl == 10'd814;
         regWrite(1, `RP_SEL_DA, da);
         regWrite(1, `RP_SEL_DC, dc);
         checkReg(1, `RP_SEL_DA, da, "DA");
         checkReg(1, `RP_SEL_DC, dc, "DC");
         checkDsBit(1, `RP_DS_LST, lst, "LST");
      end
   endtask

   task automatic testSeek();
      rpCyl_t cyl;
      cyl = rpCyl_t'($unsigned($random(seed)) % 815);
      regWrite(0, `RP_SEL_DC, {6'b0, cyl});
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_SEEK));
      checkDsBit(0, `RP_DS_PIP, 1'b1, "PIP");
      waitStatus(0, `RP_DS_DRY, 1'b1);
      checkDsBit(0, `RP_DS_ATA, 1'b1, "ATA");
      checkDsBit(0, `RP_DS_ERR, 1'b0, "ERR");
      checkReg(0, `RP_SEL_AS, 16'h0001, "AS");
      regWrite(0, `RP_SEL_AS, 16'h0001);
      checkDsBit(0, `RP_DS_ATA, 1'b0, "ATA");
      // Beyond the last cylinder
      regWrite(0, `RP_SEL_DC, 16'd900);
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_SEEK));
      waitStatus(0, `RP_DS_DRY, 1'b1);
      checkReg(0, `RP_SEL_ER1, 16'h0001 << `RP_ER1_IAE, "ER1");
      checkDsBit(0, `RP_DS_ERR, 1'b1, "ERR");
      checkDsBit(0, `RP_DS_ATA, 1'b1, "ATA");
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_DRVCLR));
      waitStatus(0, `RP_DS_DRY, 1'b1);
      checkReg(0, `RP_SEL_ER1, 16'h0000, "ER1");
      checkDsBit(0, `RP_DS_ERR, 1'b0, "ERR");
      checkDsBit(0, `RP_DS_ATA, 1'b0, "ATA");
   endtask

   task automatic testSharedPositioner();
      rpCyl_t cyl0;
      rpCyl_t cyl1;
      cyl0 = rpCyl_t'($unsigned($random(seed)) % 815);
      cyl1 = rpCyl_t'($unsigned($random(seed)) % 815);
      regWrite(0, `RP_SEL_DC, {6'b0, cyl0});
      regWrite(1, `RP_SEL_DC, {6'b0, cyl1});
      // Back to back GO writes
      regWrite(0, `RP_SEL_CS1, cmdWord(`RP_FN_SEEK));
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_SEEK));
      checkDsBit(0, `RP_DS_PIP, 1'b1, "PIP");
      checkDsBit(1, `RP_DS_PIP, 1'b1, "PIP");
      waitStatus(0, `RP_DS_DRY, 1'b1);
      // Drive 1 still waits for or runs its own seek
      checkDsBit(1, `RP_DS_PIP, 1'b1, "PIP");
      waitStatus(1, `RP_DS_DRY, 1'b1);
      checkDsBit(0, `RP_DS_ATA, 1'b1, "ATA");
      checkDsBit(1, `RP_DS_ATA, 1'b1, "ATA");
      checkReg(0, `RP_SEL_AS, 16'h0003, "AS");
      regWrite(0, `RP_SEL_AS, 16'h0002);
      checkReg(1, `RP_SEL_AS, 16'h0001, "AS");
      regWrite(1, `RP_SEL_AS, 16'h0001);
   endtask

   task automatic testOffsetCenter();
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_PAKACK));
      waitStatus(1, `RP_DS_DRY, 1'b1);
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_OFFSET));
      waitStatus(1, `RP_DS_DRY, 1'b1);
      checkDsBit(1, `RP_DS_OM, 1'b1, "OM");
      checkDsBit(1, `RP_DS_ATA, 1'b1, "ATA");
      regWrite(1, `RP_SEL_AS, 16'h0002);
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_CENTER));
      waitStatus(1, `RP_DS_DRY, 1'b1);
      checkDsBit(1, `RP_DS_OM, 1'b0, "OM");
      checkDsBit(1, `RP_DS_ATA, 1'b1, "ATA");
      // Back into offset, then drive clear
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_OFFSET));
      waitStatus(1, `RP_DS_DRY, 1'b1);
      checkDsBit(1, `RP_DS_OM, 1'b1, "OM");
      regWrite(1, `RP_SEL_CS1, cmdWord(`RP_FN_DRVCLR));
      waitStatus(1, `RP_DS_DRY, 1'b1);
      checkReg(1, `RP_SEL_DS, dsWord(0, 0, 0, 1, 0, 0, 1, 0, 0), "DS after drive clear");
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      seed      = 32'h98fd2d09;
      clk       = 1'b0;
      rst       = 1'b1;
      regWr     = 1'b0;
      regDrive  = 1'b0;
      regSel    = '0;
      regWrData = '0;
      cd        = 2'b11;
      wp        = 2'b00;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      testResetStatus();
      testPresetPack();
      testLastSector();
      testSeek();
      testSharedPositioner();
      testOffsetCenter();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: rpDrive.f
+incdir+include
hw/rpPkg.sv
hw/rpRegIf.sv
hw/rpMediaIf.sv
hw/rpStatus.sv
hw/rpDrive.sv
hw/rpMassbus.sv
hw/rpPositioner.sv
hw/rpDriveTop.sv
verification/rpDriveTb.sv

// File: build.sh
#!/bin/sh
# Build and run the RP06 drive subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module rpDriveTb \
   -f rpDrive.f \
   -o VrpDriveTb

# The simulation may stop with an error, so keep its log either way
if ./obj_dir/VrpDriveTb > sim.log 2>&1; then
   :
fi
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
